// File: verilog.f
+incdir+.
pinmux_pkg.sv
intr_stat_reg.sv
reg_bus_slave.sv
glbl_regs.sv
gpio_regs.sv
pinmux_regs_top.sv
tb_pinmux_regs.sv

// File: Bender.yml
package:
  name: pinmux_regs

sources:
  - pinmux_pkg.sv
  - intr_stat_reg.sv
  - reg_bus_slave.sv
  - glbl_regs.sv
  - gpio_regs.sv
  - pinmux_regs_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pinmux_regs.sv

// File: tb_pinmux_model.svh
// ------------------------------------------------
// Reference model of the pinmux register map
// Shadow registers, write rules, interrupt rules
// ------------------------------------------------
`ifndef TB_PINMUX_MODEL_SVH
`define TB_PINMUX_MODEL_SVH

// Shadow copies of every register
logic [31:0] m_glbl_ctrl;
logic [31:0] m_intr_mask;
logic [7:0]  m_stat_sw_lo;
logic [3:0]  m_stat_sw_hi;
logic [7:0]  m_stat_hw;
logic [31:0] m_gpio_in;
logic [31:0] m_gpio_out;
logic [31:0] m_gpio_dir;
logic [31:0] m_gpio_mask;
logic [31:0] m_gpio_stat;

// Enabled bytes replace the old ones
function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                            input logic [31:0] wdata,
                                            input logic [3:0]  be);
  logic [31:0] res;
  int          b;
  res = cur;
  for (b = 0; b < 4; b++) begin
    if (be[b])
      res[8*b +: 8] = wdata[8*b +: 8];
  end
  return res;
endfunction

// Global status word, top 12 bits unused
function automatic logic [31:0] stat_word();
  return {12'h000, m_stat_sw_hi, m_stat_hw, m_stat_sw_lo};
endfunction

// Masked GPIO status sets global bit 15, sticky
task automatic note_gpio_irq();
  if (|(m_gpio_stat & m_gpio_mask))
    m_stat_hw[7] = 1'b1;
endtask

task automatic apply_write(input logic [4:0] idx, input logic [31:0] wdata,
                           input logic [3:0] be);
  logic [31:0] lanes;
  lanes = merge_bytes(32'h0, 32'hffff_ffff, be);
  case (idx)
    IDX_GLBL_CTRL:  m_glbl_ctrl = merge_bytes(m_glbl_ctrl, wdata, be);
    IDX_INTR_MASK:  m_intr_mask = merge_bytes(m_intr_mask, wdata, be);
    IDX_INTR_STAT: begin
      if (be[0])
        m_stat_sw_lo = wdata[7:0];
      if (be[2])
        m_stat_sw_hi = wdata[19:16];
      // Hardware byte is write-one-to-clear
      if (be[1])
        m_stat_hw = m_stat_hw & ~wdata[15:8];
    end
    IDX_GPIO_OUT:   m_gpio_out  = merge_bytes(m_gpio_out, wdata, be);
    IDX_GPIO_DIR:   m_gpio_dir  = merge_bytes(m_gpio_dir, wdata, be);
    IDX_GPIO_IMASK: m_gpio_mask = merge_bytes(m_gpio_mask, wdata, be);
    IDX_GPIO_ISTAT: m_gpio_stat = m_gpio_stat & ~(wdata & lanes);
    // Set alias ignores byte enables
    IDX_GPIO_ISET:  m_gpio_stat = m_gpio_stat | wdata;
    default: ;
  endcase
  // A live GPIO interrupt wins over the clear
  note_gpio_irq();
endtask

function automatic logic [31:0] expected_read(input logic [4:0] idx);
  case (idx)
    IDX_CHIP_ID:    return 32'h8268_1301;
    IDX_GLBL_CTRL:  return m_glbl_ctrl;
    IDX_INTR_MASK:  return m_intr_mask;
    IDX_INTR_STAT:  return stat_word();
    IDX_GPIO_IN:    return m_gpio_in;
    IDX_GPIO_OUT:   return m_gpio_out;
    IDX_GPIO_DIR:   return m_gpio_dir;
    IDX_GPIO_ISTAT: return m_gpio_stat;
    IDX_GPIO_ISET:  return m_gpio_stat;
    IDX_GPIO_IMASK: return m_gpio_mask;
    default:        return 32'h0;
  endcase
endfunction

// Control bits 0..6 and 8..9 to reset outputs
function automatic rst_ctrl_t expected_rst();
  rst_ctrl_t e;
  e.cpu_intf_rst_n = m_glbl_ctrl[0];
  e.qspim_rst_n    = m_glbl_ctrl[1];
  e.sspim_rst_n    = m_glbl_ctrl[2];
  e.uart_rst_n     = {m_glbl_ctrl[6], m_glbl_ctrl[3]};
  e.i2cm_rst_n     = m_glbl_ctrl[4];
  e.usb_rst_n      = m_glbl_ctrl[5];
  e.cpu_core_rst_n = m_glbl_ctrl[9:8];
  return e;
endfunction

function automatic irq_out_t expected_irq();
  logic [31:0] m;
  irq_out_t    e;
  m = m_intr_mask & stat_word();
  e.irq_lines = m[15:0];
  e.soft_irq  = m[16];
  e.user_irq  = m[19:17];
  return e;
endfunction

`endif

// File: tb_pinmux_regs.sv
// ------------------------------------------------
// Testbench for the pinmux register block
// Clock, reset, random bus traffic, checks, watchdog
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_pinmux_regs
  import pinmux_pkg::*;
();

  localparam int CLK_NS   = 8;
  localparam int NUM_ITER = 32;
  localparam int ACK_TMO  = 16;
  // Upper bound on bus accesses over all tests
  localparam int MAX_ACC  = 10 * NUM_ITER + 100;
  localparam int WDOG_NS  = (MAX_ACC * 10 + 100) * CLK_NS;

  logic        mclk;
  logic        h_reset_n;
  logic        reg_cs;
  logic        reg_wr;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [3:0]  reg_be;
  logic [31:0] reg_rdata;
  logic        reg_ack;
  hw_intr_t    hw_src;
  logic [31:0] gpio_in_data;
  logic [31:0] gpio_int_event;
  rst_ctrl_t   rst_ctrl;
  irq_out_t    irq_out;
  logic [31:0] cfg_gpio_out_data;
  logic [31:0] cfg_gpio_dir_sel;
  logic [31:0] cfg_gpio_data_in;
  logic [31:0] gpio_prev_indata;
  integer      seed;

  `include "tb_pinmux_model.svh"

  pinmux_regs_top dut (
    .mclk              (mclk),
    .h_reset_n         (h_reset_n),
    .reg_cs            (reg_cs),
    .reg_wr            (reg_wr),
    .reg_addr          (reg_addr),
    .reg_wdata         (reg_wdata),
    .reg_be            (reg_be),
    .reg_rdata         (reg_rdata),
    .reg_ack           (reg_ack),
    .ext_intr_in       (hw_src.ext),
    .usb_intr          (hw_src.usb),
    .i2cm_intr         (hw_src.i2cm),
    .timer_intr        (hw_src.timer),
    .gpio_in_data      (gpio_in_data),
    .gpio_int_event    (gpio_int_event),
    .rst_ctrl          (rst_ctrl),
    .irq_out           (irq_out),
    .cfg_gpio_out_data (cfg_gpio_out_data),
    .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
    .cfg_gpio_data_in  (cfg_gpio_data_in),
    .gpio_prev_indata  (gpio_prev_indata)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_NS / 2) mclk = ~mclk;
  end

  // ------------------------------------------------
  // Error handling and compares
  // ------------------------------------------------
  task automatic stop_on_error(input string what);
    $display("SIMULATION FAILED");
    $display("%s", what);
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
      stop_on_error($sformatf("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act));
  endtask

  task automatic check_rst(input rst_ctrl_t exp, input rst_ctrl_t act);
    if (exp !== act)
      stop_on_error($sformatf("[FAIL] t=%0t rst_ctrl expected %h got %h", $time, exp, act));
  endtask

  task automatic check_irq(input irq_out_t exp, input irq_out_t act);
    if (exp !== act)
      stop_on_error($sformatf("[FAIL] t=%0t irq_out expected %h got %h", $time, exp, act));
  endtask

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // One edge of settling for the GPIO to global interrupt path
  task automatic check_outputs();
    @(negedge mclk);
    check_rst(expected_rst(), rst_ctrl);
    check_irq(expected_irq(), irq_out);
    check_word("cfg_gpio_out_data", m_gpio_out, cfg_gpio_out_data);
    check_word("cfg_gpio_dir_sel", m_gpio_dir, cfg_gpio_dir_sel);
  endtask

  // ------------------------------------------------
  // Bus master holds the request until ack and over the commit edge
  // ------------------------------------------------
  task automatic bus_access(input logic wr, input logic [4:0] idx, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    int n;
    n = 0;
    @(negedge mclk);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = {1'b0, idx, 2'b00};
    reg_wdata = wdata;
    reg_be    = be;
    @(negedge mclk);
    while (!reg_ack) begin
      if (n == ACK_TMO)
        stop_on_error("Timeout: reg_ack never came back for a bus request");
      else begin
        n++;
        @(negedge mclk);
      end
    end
    // Ack is due on the first edge that samples the request
    if (n != 0)
      stop_on_error($sformatf("reg_ack came %0d cycles late for a bus request", n));
    rdata = reg_rdata;
    // Hold across the ack edge so the commit happens
    @(negedge mclk);
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    // Ack lasts a single cycle
    if (reg_ack !== 1'b0)
      stop_on_error("reg_ack stayed high for a second cycle");
  endtask

  task automatic write_reg(input logic [4:0] idx, input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] rd;
    bus_access(1'b1, idx, wdata, be, rd);
    apply_write(idx, wdata, be);
    check_outputs();
  endtask

  task automatic read_check(input logic [4:0] idx);
    logic [31:0] rd;
    bus_access(1'b0, idx, 32'h0, 4'hf, rd);
    check_word($sformatf("reg_rdata[idx %0d]", idx), expected_read(idx), rd);
  endtask

  // One-cycle pulses on hardware sources
  task automatic pulse_hw(input logic [6:0] bits);
    @(negedge mclk);
    hw_src = hw_intr_t'({1'b0, bits});
    @(negedge mclk);
    hw_src = '0;
    m_stat_hw = m_stat_hw | {1'b0, bits};
    check_outputs();
  endtask

  task automatic pulse_event(input logic [31:0] ev);
    @(negedge mclk);
    gpio_int_event = ev;
    @(negedge mclk);
    gpio_int_event = '0;
    m_gpio_stat = m_gpio_stat | ev;
    note_gpio_irq();
    check_outputs();
  endtask

  // Watchdog
  initial begin
    #(WDOG_NS);
    stop_on_error("Timeout: watchdog expired before the tests finished");
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------
  initial begin
    logic [4:0]  widx [5];
    logic [31:0] r;
    int          i;
    widx = '{IDX_GLBL_CTRL, IDX_INTR_MASK, IDX_GPIO_OUT, IDX_GPIO_DIR, IDX_GPIO_IMASK};
    seed = 32'h42a3_fac2;
    h_reset_n = 1'b0;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    reg_be = '0;
    hw_src = '0;
    gpio_in_data = '0;
    gpio_int_event = '0;
    m_glbl_ctrl = '0;
    m_intr_mask = '0;
    m_stat_sw_lo = '0;
    m_stat_sw_hi = '0;
    m_stat_hw = '0;
    m_gpio_in = '0;
    m_gpio_out = '0;
    m_gpio_dir = '0;
    m_gpio_mask = '0;
    m_gpio_stat = '0;
    repeat (3) @(posedge mclk);
    @(negedge mclk);
    h_reset_n = 1'b1;

    // Reset values, chip ID and unmapped words
    check_outputs();
    check_word("reg_rdata", 32'h0, reg_rdata);
    if (reg_ack !== 1'b0)
      stop_on_error("reg_ack is high after reset without a request");
    read_check(IDX_CHIP_ID);
    read_check(5'd2);
    read_check(5'd8);
    read_check(5'd12);
    read_check(5'd31);

    // Byte-enabled writes to plain registers
    for (i = 0; i < NUM_ITER; i++) begin
      r = next_rand();
      write_reg(widx[r[2:0] % 5], next_rand(), r[7:4]);
      read_check(widx[r[2:0] % 5]);
    end

    // Static input through the synchroniser
    for (i = 0; i < 4; i++) begin
      @(negedge mclk);
      gpio_in_data = next_rand();
      // Previous-value output leads the register by one edge
      repeat (2) @(negedge mclk);
      check_word("gpio_prev_indata", gpio_in_data, gpio_prev_indata);
      check_word("cfg_gpio_data_in", m_gpio_in, cfg_gpio_data_in);
      repeat (2) @(negedge mclk);
      m_gpio_in = gpio_in_data;
      check_word("cfg_gpio_data_in", m_gpio_in, cfg_gpio_data_in);
      check_word("gpio_prev_indata", m_gpio_in, gpio_prev_indata);
      read_check(IDX_GPIO_IN);
    end

    // GPIO status set by events and alias and cleared per byte
    for (i = 0; i < NUM_ITER; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0:    pulse_event(next_rand() & next_rand());
        2'd1:    write_reg(IDX_GPIO_ISET, next_rand() & next_rand(), r[7:4]);
        default: write_reg(IDX_GPIO_ISTAT, next_rand(), r[7:4]);
      endcase
      read_check(IDX_GPIO_ISTAT);
      read_check(IDX_GPIO_ISET);
    end

    // GPIO into global bit 15 and clear of the hardware byte
    for (i = 0; i < 8; i++) begin
      r = next_rand() | 32'h1;
      write_reg(IDX_GPIO_IMASK, r, 4'hf);
      write_reg(IDX_GPIO_ISET, next_rand() | 32'h1, 4'hf);
      read_check(IDX_INTR_STAT);
      pulse_hw(r[14:8]);
      read_check(IDX_INTR_STAT);
      write_reg(IDX_INTR_STAT, 32'h0000_ff00, 4'b0010);
      read_check(IDX_INTR_STAT);
      write_reg(IDX_GPIO_ISTAT, 32'hffff_ffff, 4'hf);
      write_reg(IDX_INTR_STAT, 32'h0000_ff00, 4'b0010);
      read_check(IDX_INTR_STAT);
    end

    // Mask and status against irq_out
    for (i = 0; i < NUM_ITER; i++) begin
      r = next_rand();
      write_reg(IDX_INTR_MASK, next_rand(), r[3:0]);
      write_reg(IDX_INTR_STAT, next_rand(), r[7:4]);
      read_check(IDX_INTR_STAT);
    end

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: pinmux_regs_top.sv
// ------------------------------------------------
// Pinmux register block top
// Bus slave with global and GPIO banks
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module pinmux_regs_top
  import pinmux_pkg::*;
(
  input  logic              mclk,
  input  logic              h_reset_n,
  // Register bus
  input  logic              reg_cs,
  input  logic              reg_wr,
  input  logic [7:0]        reg_addr,
  input  logic [DATA_W-1:0] reg_wdata,
  input  logic [BE_W-1:0]   reg_be,
  output logic [DATA_W-1:0] reg_rdata,
  output logic              reg_ack,
  // Hardware interrupt sources
  input  logic [1:0]        ext_intr_in,
  input  logic              usb_intr,
  input  logic              i2cm_intr,
  input  logic [2:0]        timer_intr,
  // GPIO pins
  input  logic [GPIO_W-1:0] gpio_in_data,
  input  logic [GPIO_W-1:0] gpio_int_event,
  // Control outputs
  output rst_ctrl_t         rst_ctrl,
  output irq_out_t          irq_out,
  output logic [GPIO_W-1:0] cfg_gpio_out_data,
  output logic [GPIO_W-1:0] cfg_gpio_dir_sel,
  output logic [GPIO_W-1:0] cfg_gpio_data_in,
  output logic [GPIO_W-1:0] gpio_prev_indata
);

  reg_req_t          reg_req;
  logic [DATA_W-1:0] glbl_rdata;
  logic [DATA_W-1:0] gpio_rdata;
  logic              gpio_intr;
  hw_intr_t          hw_intr;

  // Source order as in the status byte
  assign hw_intr.gpio  = gpio_intr;
  assign hw_intr.ext   = ext_intr_in;
  assign hw_intr.usb   = usb_intr;
  assign hw_intr.i2cm  = i2cm_intr;
  assign hw_intr.timer = timer_intr;

  reg_bus_slave u_slave (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .glbl_rdata (glbl_rdata),
    .gpio_rdata (gpio_rdata),
    .reg_req    (reg_req),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack)
  );

  glbl_regs u_glbl (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_req   (reg_req),
    .hw_intr   (hw_intr),
    .rdata     (glbl_rdata),
    .rst_ctrl  (rst_ctrl),
    .irq_out   (irq_out)
  );

  gpio_regs u_gpio (
    .mclk              (mclk),
    .h_reset_n         (h_reset_n),
    .reg_req           (reg_req),
    .gpio_in_data      (gpio_in_data),
    .gpio_int_event    (gpio_int_event),
    .rdata             (gpio_rdata),
    .cfg_gpio_out_data (cfg_gpio_out_data),
    .cfg_gpio_dir_sel  (cfg_gpio_dir_sel),
    .cfg_gpio_data_in  (cfg_gpio_data_in),
    .gpio_prev_indata  (gpio_prev_indata),
    .gpio_intr         (gpio_intr)
  );

endmodule

`default_nettype wire

// File: gpio_regs.sv
// ------------------------------------------------
// GPIO register bank
// Input capture, output data and direction
// GPIO interrupt status, set alias and mask
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module gpio_regs
  import pinmux_pkg::*;
(
  input  logic              mclk,
  input  logic              h_reset_n,
  input  reg_req_t          reg_req,
  input  logic [GPIO_W-1:0] gpio_in_data,
  input  logic [GPIO_W-1:0] gpio_int_event,
  output logic [DATA_W-1:0] rdata,
  output logic [GPIO_W-1:0] cfg_gpio_out_data,
  output logic [GPIO_W-1:0] cfg_gpio_dir_sel,
  output logic [GPIO_W-1:0] cfg_gpio_data_in,
  output logic [GPIO_W-1:0] gpio_prev_indata,
  output logic              gpio_intr
);

  reg_idx_e          idx;
  logic [GPIO_W-1:0] in_s;
  logic [GPIO_W-1:0] in_ss;
  logic [GPIO_W-1:0] in_q;
  logic [GPIO_W-1:0] int_mask;
  logic [GPIO_W-1:0] int_stat;
  logic [GPIO_W-1:0] stat_set;
  logic [GPIO_W-1:0] stat_clr;

  assign idx = reg_idx_e'(reg_req.idx);

  // Two sync stages then the GPIO_IN register
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      in_s  <= '0;
      in_ss <= '0;
      in_q  <= '0;
    end else begin
      in_s  <= gpio_in_data;
      in_ss <= in_s;
      in_q  <= in_ss;
    end
  end

  assign gpio_prev_indata = in_ss;
  assign cfg_gpio_data_in = in_q;

  // ------------------------------------------------
  // Configuration registers
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      cfg_gpio_out_data <= REG_RST_VAL;
      cfg_gpio_dir_sel  <= REG_RST_VAL;
      int_mask          <= REG_RST_VAL;
    end else if (reg_req.wr) begin
      if (idx == IDX_GPIO_OUT)
        cfg_gpio_out_data <= be_merge(cfg_gpio_out_data, reg_req.wdata, reg_req.be);
      if (idx == IDX_GPIO_DIR)
        cfg_gpio_dir_sel  <= be_merge(cfg_gpio_dir_sel, reg_req.wdata, reg_req.be);
      if (idx == IDX_GPIO_IMASK)
        int_mask          <= be_merge(int_mask, reg_req.wdata, reg_req.be);
    end
  end

  // Pin events plus set-alias ones
  assign stat_set = gpio_int_event
                  | ({GPIO_W{reg_req.commit && idx == IDX_GPIO_ISET}} & reg_req.wdata);
  // Write-one-to-clear gated per byte lane
  assign stat_clr = {GPIO_W{reg_req.commit && idx == IDX_GPIO_ISTAT}}
                  & be_to_mask(reg_req.be) & reg_req.wdata;

  intr_stat_reg #(.WD(GPIO_W)) u_gpio_stat (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr       (stat_clr),
    .set       (stat_set),
    .stat      (int_stat)
  );

  assign gpio_intr = |(int_stat & int_mask);

  // Set alias reads back the status
  always_comb begin
    case (idx)
      IDX_GPIO_IN:    rdata = in_q;
      IDX_GPIO_OUT:   rdata = cfg_gpio_out_data;
      IDX_GPIO_DIR:   rdata = cfg_gpio_dir_sel;
      IDX_GPIO_ISTAT: rdata = int_stat;
      IDX_GPIO_ISET:  rdata = int_stat;
      IDX_GPIO_IMASK: rdata = int_mask;
      default:        rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: glbl_regs.sv
// ------------------------------------------------
// Global register bank
// Chip ID, global control and reset outputs
// Global interrupt mask, status and masked IRQs
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module glbl_regs
  import pinmux_pkg::*;
(
  input  logic              mclk,
  input  logic              h_reset_n,
  input  reg_req_t          reg_req,
  input  hw_intr_t          hw_intr,
  output logic [DATA_W-1:0] rdata,
  output rst_ctrl_t         rst_ctrl,
  output irq_out_t          irq_out
);

  reg_idx_e          idx;
  logic [DATA_W-1:0] glbl_ctrl;
  logic [DATA_W-1:0] intr_mask;
  logic [7:0]        stat_sw_lo;   // status byte 0
  logic [3:0]        stat_sw_hi;   // status bits 19:16
  logic [7:0]        stat_hw;      // status byte 1
  logic [HW_INTR_W-1:0] stat_hw_clr;
  logic [DATA_W-1:0] intr_stat;
  logic [DATA_W-1:0] irq_masked;

  assign idx = reg_idx_e'(reg_req.idx);

  // ------------------------------------------------
  // Plain registers, written on every wr cycle
  // ------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      glbl_ctrl  <= REG_RST_VAL;
      intr_mask  <= REG_RST_VAL;
      stat_sw_lo <= '0;
      stat_sw_hi <= '0;
    end else if (reg_req.wr) begin
      if (idx == IDX_GLBL_CTRL)
        glbl_ctrl <= be_merge(glbl_ctrl, reg_req.wdata, reg_req.be);
      if (idx == IDX_INTR_MASK)
        intr_mask <= be_merge(intr_mask, reg_req.wdata, reg_req.be);
      // Software status bytes
      if (idx == IDX_INTR_STAT && reg_req.be[0])
        stat_sw_lo <= reg_req.wdata[7:0];
      if (idx == IDX_INTR_STAT && reg_req.be[2])
        stat_sw_hi <= reg_req.wdata[19:16];
    end
  end

  // Hardware byte, ones clear once per access
  assign stat_hw_clr = {HW_INTR_W{reg_req.commit && idx == IDX_INTR_STAT && reg_req.be[1]}}
                       & reg_req.wdata[15:8];

  intr_stat_reg #(.WD(HW_INTR_W)) u_hw_stat (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .clr       (stat_hw_clr),
    .set       (hw_intr),
    .stat      (stat_hw)
  );

  // Bits 31:20 unimplemented
  assign intr_stat = {12'h000, stat_sw_hi, stat_hw, stat_sw_lo};

  // ------------------------------------------------
  // Outputs
  // ------------------------------------------------
  assign rst_ctrl.cpu_intf_rst_n = glbl_ctrl[0];
  assign rst_ctrl.qspim_rst_n    = glbl_ctrl[1];
  assign rst_ctrl.sspim_rst_n    = glbl_ctrl[2];
  assign rst_ctrl.uart_rst_n     = {glbl_ctrl[6], glbl_ctrl[3]};
  assign rst_ctrl.i2cm_rst_n     = glbl_ctrl[4];
  assign rst_ctrl.usb_rst_n      = glbl_ctrl[5];
  assign rst_ctrl.cpu_core_rst_n = glbl_ctrl[9:8];

  assign irq_masked        = intr_mask & intr_stat;
  assign irq_out.irq_lines = irq_masked[15:0];
  assign irq_out.soft_irq  = irq_masked[16];
  assign irq_out.user_irq  = irq_masked[19:17];

  // Read mux, zero outside this bank
  always_comb begin
    case (idx)
      IDX_CHIP_ID:   rdata = CHIP_ID_VAL;
      IDX_GLBL_CTRL: rdata = glbl_ctrl;
      IDX_INTR_MASK: rdata = intr_mask;
      IDX_INTR_STAT: rdata = intr_stat;
      default:       rdata = '0;
    endcase
  end

  a_soft_irq_masked: assert property (
    @(posedge mclk) disable iff (!h_reset_n) irq_out.soft_irq |-> intr_mask[16]
  );

endmodule

`default_nettype wire

// File: reg_bus_slave.sv
// ------------------------------------------------
// Register bus slave
// Single-cycle ack, write request bundle, read capture
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module reg_bus_slave
  import pinmux_pkg::*;
(
  input  logic              mclk,
  input  logic              h_reset_n,
  // CPU register bus
  input  logic              reg_cs,
  input  logic              reg_wr,
  input  logic [7:0]        reg_addr,
  input  logic [DATA_W-1:0] reg_wdata,
  input  logic [BE_W-1:0]   reg_be,
  // Bank read words
  input  logic [DATA_W-1:0] glbl_rdata,
  input  logic [DATA_W-1:0] gpio_rdata,
  // To the banks
  output reg_req_t          reg_req,
  output logic [DATA_W-1:0] reg_rdata,
  output logic              reg_ack
);

  logic wr_req;

  assign wr_req = reg_cs & reg_wr;

  // Write request to both banks
  assign reg_req.wr     = wr_req;
  assign reg_req.commit = wr_req & reg_ack;
  assign reg_req.idx    = reg_addr[6:2];
  assign reg_req.wdata  = reg_wdata;
  assign reg_req.be     = reg_be;

  // ------------------------------------------------
  // Ack and read capture
  // ------------------------------------------------
  // First edge with cs high and ack low captures data
  // Ack drops on the following edge
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else if (reg_cs && !reg_ack) begin
      reg_ack   <= 1'b1;
      // Banks return zero for indices they do not own
      reg_rdata <= glbl_rdata | gpio_rdata;
    end else begin
      reg_ack   <= 1'b0;
    end
  end

  // Ack is a single pulse, a held cs gets an idle cycle between accesses
  a_ack_single: assert property (
    @(posedge mclk) disable iff (!h_reset_n) reg_ack |=> !reg_ack
  );

endmodule

`default_nettype wire

// File: intr_stat_reg.sv
// ------------------------------------------------
// Interrupt status bits
// Hardware set wins over write-one-to-clear
// ------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module intr_stat_reg #(
  parameter int WD = 8
) (
  input  logic          mclk,
  input  logic          h_reset_n,
  input  logic [WD-1:0] clr,
  input  logic [WD-1:0] set,
  output logic [WD-1:0] stat
);

  // Updated every cycle
  // set > clr > hold, per bit
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      stat <= '0;
    end else begin
      stat <= set | (stat & ~clr);
    end
  end

endmodule

`default_nettype wire

// File: pinmux_pkg.sv
// ------------------------------------------------
// Shared widths, register word indices and reset values
// Request, reset and interrupt bundles
// Byte-enable helper functions
// ------------------------------------------------
`default_nettype none

package pinmux_pkg;

  // Bus geometry
  localparam int DATA_W    = 32;
  localparam int BE_W      = 4;
  localparam int IDX_W     = 5;

  // Pin and interrupt source counts
  localparam int GPIO_W    = 32;
  localparam int HW_INTR_W = 8;

  // Manufacturer 8268, one core, chip 3, revision 01
  localparam logic [DATA_W-1:0] CHIP_ID_VAL = 32'h8268_1301;

  // Reset value of every writable register
  localparam logic [DATA_W-1:0] REG_RST_VAL = '0;

  // Word index, address bits 6 to 2
  typedef enum logic [IDX_W-1:0] {
    IDX_CHIP_ID    = 5'd0,
    IDX_GLBL_CTRL  = 5'd1,
    IDX_INTR_MASK  = 5'd3,
    IDX_INTR_STAT  = 5'd4,
    IDX_GPIO_IN    = 5'd5,
    IDX_GPIO_OUT   = 5'd6,
    IDX_GPIO_DIR   = 5'd7,
    IDX_GPIO_ISTAT = 5'd9,
    IDX_GPIO_ISET  = 5'd10,
    IDX_GPIO_IMASK = 5'd11
  } reg_idx_e;

  // ------------------------------------------------
  // Bundles
  // ------------------------------------------------
  typedef struct packed {
    logic              wr;      // cs and write, whole access
    logic              commit;  // write in the ack cycle only
    logic [IDX_W-1:0]  idx;
    logic [DATA_W-1:0] wdata;
    logic [BE_W-1:0]   be;
  } reg_req_t;

  // Active low reset outputs
  typedef struct packed {
    logic [1:0] cpu_core_rst_n;
    logic       cpu_intf_rst_n;
    logic       qspim_rst_n;
    logic       sspim_rst_n;
    logic [1:0] uart_rst_n;
    logic       i2cm_rst_n;
    logic       usb_rst_n;
  } rst_ctrl_t;

  // Hardware sources, top bit first
  typedef struct packed {
    logic       gpio;
    logic [1:0] ext;
    logic       usb;
    logic       i2cm;
    logic [2:0] timer;
  } hw_intr_t;

  typedef struct packed {
    logic [15:0] irq_lines;
    logic        soft_irq;
    logic [2:0]  user_irq;
  } irq_out_t;

  // Expand byte enables to a bit mask
  function automatic logic [DATA_W-1:0] be_to_mask(input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] m;
    for (int i = 0; i < BE_W; i++) begin
      m[8*i +: 8] = {8{be[i]}};
    end
    return m;
  endfunction

  // Merge enabled write bytes into the current value
  function automatic logic [DATA_W-1:0] be_merge(input logic [DATA_W-1:0] cur,
                                                 input logic [DATA_W-1:0] wdata,
                                                 input logic [BE_W-1:0]   be);
    logic [DATA_W-1:0] m;
    m = be_to_mask(be);
    return (wdata & m) | (cur & ~m);
  endfunction

endpackage

`default_nettype wire
